// ==== hw/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// -------------------
// datapath sizes
// -------------------
`define WORD_W          16      // data and address width
`define REG_N           4       // architectural registers
`define REG_AW          2       // register address width

// -------------------
// instruction fields
// -------------------
`define OPC_MSB         15
`define OPC_LSB         12
`define RS_MSB          11
`define RS_LSB          10
`define RT_MSB          9
`define RT_LSB          8
`define RD_MSB          7
`define RD_LSB          6
`define FUNC_MSB        5
`define FUNC_LSB        0
`define IMM_MSB         7
`define IMM_LSB         0

`define RESET_PC        16'h0000        // first fetch address

`endif

// ==== hw/isa_pkg.sv ====
`include "cpu_consts.svh"

package isa_pkg;

        // major opcodes, only the kept ones
        typedef enum logic [`OPC_MSB-`OPC_LSB:0] {
                OPC_ADI   = 4'd4,
                OPC_ORI   = 4'd5,
                OPC_LHI   = 4'd6,
                OPC_RTYPE = 4'd15
        } opcode_e;

        // function field of r-type words
        typedef enum logic [`FUNC_MSB-`FUNC_LSB:0] {
                FUNC_ADD = 6'd0,
                FUNC_SUB = 6'd1,
                FUNC_AND = 6'd2,
                FUNC_ORR = 6'd3,
                FUNC_NOT = 6'd4,
                FUNC_TCP = 6'd5,
                FUNC_SHL = 6'd6,
                FUNC_SHR = 6'd7,
                FUNC_WWD = 6'd28,
                FUNC_HLT = 6'd29
        } func_e;

        // operation selected in execute
        typedef enum logic [3:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_NOT,
                ALU_TCP,
                ALU_SHL,
                ALU_SHR,
                ALU_LHI         // immediate into upper byte
        } alu_op_e;

endpackage

// ==== hw/pipe_pkg.sv ====
`include "cpu_consts.svh"

package pipe_pkg;

        // decode -> execute
        typedef struct packed {
                logic                   valid;
                isa_pkg::alu_op_e       alu_op;
                logic [`REG_AW-1:0]     rs;
                logic [`REG_AW-1:0]     rt;
                logic [`REG_AW-1:0]     dest;   // rd or rt, already chosen
                logic                   reg_write;
                logic                   use_imm;
                logic [`WORD_W-1:0]     imm;    // extended immediate
                logic                   wwd;
                logic                   halt;
                logic [`WORD_W-1:0]     opa;    // register value of rs
                logic [`WORD_W-1:0]     opb;    // register value of rt
        } id_ex_t;

        // execute -> writeback
        typedef struct packed {
                logic                   valid;
                logic [`REG_AW-1:0]     dest;
                logic                   reg_write;
                logic [`WORD_W-1:0]     result;
                logic                   wwd;
                logic                   halt;
        } ex_wb_t;

endpackage

// ==== hw/rf_if.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

interface rf_if;

        // read side, both combinational
        logic [`REG_AW-1:0]     rd_addr_a;
        logic [`REG_AW-1:0]     rd_addr_b;
        logic [`WORD_W-1:0]     rd_data_a;
        logic [`WORD_W-1:0]     rd_data_b;

        // write side, taken at the clock edge
        logic                   wr_en;
        logic [`REG_AW-1:0]     wr_addr;
        logic [`WORD_W-1:0]     wr_data;

        modport decode (output rd_addr_a, rd_addr_b, input rd_data_a, rd_data_b);

        modport writeback (output wr_en, wr_addr, wr_data);

        modport regfile (
                input  rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
                output rd_data_a, rd_data_b
        );

endinterface

// ==== hw/fetch_unit.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module fetch_unit (
        input  logic                    clk,
        input  logic                    reset_n,
        input  logic [`WORD_W-1:0]      i_instr,
        input  logic                    i_halt_seen,
        output logic [`WORD_W-1:0]      o_pc,
        output logic                    o_read,
        output logic [`WORD_W-1:0]      o_instr,
        output logic                    o_valid
);

        logic [`WORD_W-1:0]     pc_q;
        logic                   started_q;      // first cycle out of reset is idle
        logic                   halted_q;       // sticky once HLT was decoded

        // no new fetch once HLT sits in decode
        assign o_read = started_q & ~halted_q & ~i_halt_seen;
        assign o_pc   = pc_q;

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        pc_q      <= `RESET_PC;
                        started_q <= 1'b0;
                        halted_q  <= 1'b0;
                        o_valid   <= 1'b0;
                end else begin
                        started_q <= 1'b1;
                        if (i_halt_seen) begin
                                halted_q <= 1'b1;
                        end
                        if (o_read) begin
                                pc_q <= pc_q + 1'b1;    // pc hold otherwise
                        end
                        o_valid <= o_read;              // bubble when not reading
                end
        end

        // --------------------
        // IF/ID payload
        // --------------------
        always_ff @(posedge clk) begin
                o_instr <= i_instr;
        end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module decode_stage (
        input  logic                    clk,
        input  logic                    reset_n,
        input  logic [`WORD_W-1:0]      i_instr,
        input  logic                    i_valid,
        output logic                    o_halt_seen,
        rf_if.decode                    rf,
        output pipe_pkg::id_ex_t        o_id_ex
);

        import isa_pkg::*;
        import pipe_pkg::*;

        localparam int IMM_W = `IMM_MSB - `IMM_LSB + 1;

        opcode_e                opcode;
        func_e                  func;
        logic [`REG_AW-1:0]     rs;
        logic [`REG_AW-1:0]     rt;
        logic [`REG_AW-1:0]     rd;
        logic [IMM_W-1:0]       imm8;
        logic [`WORD_W-1:0]     imm_sext;
        logic [`WORD_W-1:0]     imm_zext;
        logic                   known;
        id_ex_t                 id_ex_d;
        id_ex_t                 id_ex_q;

        // --------------------
        // field split
        // --------------------
        assign opcode   = opcode_e'(i_instr[`OPC_MSB:`OPC_LSB]);
        assign func     = func_e'(i_instr[`FUNC_MSB:`FUNC_LSB]);
        assign rs       = i_instr[`RS_MSB:`RS_LSB];
        assign rt       = i_instr[`RT_MSB:`RT_LSB];
        assign rd       = i_instr[`RD_MSB:`RD_LSB];
        assign imm8     = i_instr[`IMM_MSB:`IMM_LSB];
        assign imm_sext = {{(`WORD_W-IMM_W){imm8[IMM_W-1]}}, imm8};
        assign imm_zext = {{(`WORD_W-IMM_W){1'b0}}, imm8};

        // operand reads, write-through handled in the register file
        assign rf.rd_addr_a = rs;
        assign rf.rd_addr_b = rt;

        always_comb begin
                known        = 1'b0;
                id_ex_d      = '0;
                id_ex_d.rs   = rs;
                id_ex_d.rt   = rt;
                id_ex_d.dest = rd;
                id_ex_d.imm  = imm_sext;
                id_ex_d.opa  = rf.rd_data_a;
                id_ex_d.opb  = rf.rd_data_b;
                case (opcode)
                OPC_ADI, OPC_ORI, OPC_LHI: begin
                        known             = 1'b1;
                        id_ex_d.dest      = rt;         // i-type writes rt
                        id_ex_d.reg_write = 1'b1;
                        id_ex_d.use_imm   = 1'b1;
                        if (opcode == OPC_ADI) begin
                                id_ex_d.alu_op = ALU_ADD;
                        end else begin
                                id_ex_d.imm    = imm_zext;
                                id_ex_d.alu_op = (opcode == OPC_ORI) ? ALU_OR : ALU_LHI;
                        end
                end
                OPC_RTYPE: begin
                        known             = 1'b1;
                        id_ex_d.reg_write = 1'b1;
                        case (func)
                        FUNC_ADD: id_ex_d.alu_op = ALU_ADD;
                        FUNC_SUB: id_ex_d.alu_op = ALU_SUB;
                        FUNC_AND: id_ex_d.alu_op = ALU_AND;
                        FUNC_ORR: id_ex_d.alu_op = ALU_OR;
                        FUNC_NOT: id_ex_d.alu_op = ALU_NOT;
                        FUNC_TCP: id_ex_d.alu_op = ALU_TCP;
                        FUNC_SHL: id_ex_d.alu_op = ALU_SHL;
                        FUNC_SHR: id_ex_d.alu_op = ALU_SHR;
                        FUNC_WWD: begin
                                id_ex_d.reg_write = 1'b0;
                                id_ex_d.wwd       = 1'b1;
                        end
                        FUNC_HLT: begin
                                id_ex_d.reg_write = 1'b0;
                                id_ex_d.halt      = 1'b1;
                        end
                        default: known = 1'b0;
                        endcase
                end
                default: known = 1'b0;          // unknown word, becomes a bubble
                endcase
                id_ex_d.valid = i_valid & known;
        end

        assign o_halt_seen = id_ex_d.valid & id_ex_d.halt;

        // --------------------
        // ID/EX register
        // --------------------
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        id_ex_q.valid <= 1'b0;
                end else begin
                        id_ex_q <= id_ex_d;
                end
        end

        assign o_id_ex = id_ex_q;

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module reg_file (
        input  logic    clk,
        input  logic    reset_n,
        rf_if.regfile   rf
);

        logic [`WORD_W-1:0]     regs [`REG_N];

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        for (int i = 0; i < `REG_N; i++) begin
                                regs[i] <= '0;
                        end
                end else if (rf.wr_en) begin
                        regs[rf.wr_addr] <= rf.wr_data;
                end
        end

        // same-cycle write wins over the stored word
        assign rf.rd_data_a = (rf.wr_en && rf.wr_addr == rf.rd_addr_a) ? rf.wr_data
                                                                       : regs[rf.rd_addr_a];
        assign rf.rd_data_b = (rf.wr_en && rf.wr_addr == rf.rd_addr_b) ? rf.wr_data
                                                                       : regs[rf.rd_addr_b];

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module execute_stage (
        input  logic                    clk,
        input  logic                    reset_n,
        input  pipe_pkg::id_ex_t        i_id_ex,
        output pipe_pkg::ex_wb_t        o_ex_wb
);

        import isa_pkg::*;
        import pipe_pkg::*;

        logic                   fwd_a;
        logic                   fwd_b;
        logic [`WORD_W-1:0]     op_a;
        logic [`WORD_W-1:0]     op_b_reg;
        logic [`WORD_W-1:0]     op_b;
        logic [`WORD_W-1:0]     alu_y;
        ex_wb_t                 ex_wb_d;
        ex_wb_t                 ex_wb_q;

        // --------------------
        // forwarding
        // --------------------
        // only the previous instruction needs it, older ones come via write-through
        assign fwd_a = ex_wb_q.valid && ex_wb_q.reg_write && (ex_wb_q.dest == i_id_ex.rs);
        assign fwd_b = ex_wb_q.valid && ex_wb_q.reg_write && (ex_wb_q.dest == i_id_ex.rt);

        assign op_a     = fwd_a ? ex_wb_q.result : i_id_ex.opa;
        assign op_b_reg = fwd_b ? ex_wb_q.result : i_id_ex.opb;
        assign op_b     = i_id_ex.use_imm ? i_id_ex.imm : op_b_reg;

        // --------------------
        // ALU
        // --------------------
        always_comb begin
                case (i_id_ex.alu_op)
                ALU_ADD: alu_y = op_a + op_b;           // wraps at word width
                ALU_SUB: alu_y = op_a - op_b;
                ALU_AND: alu_y = op_a & op_b;
                ALU_OR:  alu_y = op_a | op_b;
                ALU_NOT: alu_y = ~op_a;
                ALU_TCP: alu_y = ~op_a + 1'b1;
                ALU_SHL: alu_y = {op_a[`WORD_W-2:0], 1'b0};
                ALU_SHR: alu_y = {op_a[`WORD_W-1], op_a[`WORD_W-1:1]};  // keeps sign
                ALU_LHI: alu_y = {op_b[`WORD_W/2-1:0], {(`WORD_W/2){1'b0}}};
                default: alu_y = '0;
                endcase
        end

        always_comb begin
                ex_wb_d.valid     = i_id_ex.valid;
                ex_wb_d.dest      = i_id_ex.dest;
                ex_wb_d.reg_write = i_id_ex.reg_write;
                ex_wb_d.result    = i_id_ex.wwd ? op_a : alu_y;       // WWD passes A
                ex_wb_d.wwd       = i_id_ex.wwd;
                ex_wb_d.halt      = i_id_ex.halt;
        end

        // --------------------
        // EX/WB register
        // --------------------
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        ex_wb_q.valid <= 1'b0;
                end else begin
                        ex_wb_q <= ex_wb_d;
                end
        end

        assign o_ex_wb = ex_wb_q;

endmodule

// ==== hw/writeback_stage.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module writeback_stage (
        input  logic                    clk,
        input  logic                    reset_n,
        input  pipe_pkg::ex_wb_t        i_ex_wb,
        rf_if.writeback                 rf,
        output logic [`WORD_W-1:0]      o_output_port,
        output logic                    o_wwd_valid,
        output logic [`WORD_W-1:0]      o_num_inst,
        output logic                    o_is_halted
);

        import pipe_pkg::*;

        logic   retire;
        logic   is_wwd;

        assign retire = i_ex_wb.valid;
        assign is_wwd = i_ex_wb.valid & i_ex_wb.wwd;

        // register write lands at the edge that retires the instruction
        assign rf.wr_en   = i_ex_wb.valid & i_ex_wb.reg_write;
        assign rf.wr_addr = i_ex_wb.dest;
        assign rf.wr_data = i_ex_wb.result;

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        o_output_port <= '0;
                        o_wwd_valid   <= 1'b0;
                        o_num_inst    <= '0;
                        o_is_halted   <= 1'b0;
                end else begin
                        o_wwd_valid <= is_wwd;          // one-cycle strobe
                        if (is_wwd) begin
                                o_output_port <= i_ex_wb.result;
                        end
                        if (retire) begin
                                o_num_inst <= o_num_inst + 1'b1;
                        end
                        // held until the next reset
                        if (retire && i_ex_wb.halt) begin
                                o_is_halted <= 1'b1;
                        end
                end
        end

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu_top (
        input  logic                    clk,
        input  logic                    reset_n,
        output logic [`WORD_W-1:0]      o_i_address,
        output logic                    o_i_readM,
        input  logic [`WORD_W-1:0]      i_i_data,
        output logic [`WORD_W-1:0]      o_output_port,
        output logic                    o_wwd_valid,
        output logic [`WORD_W-1:0]      o_num_inst,
        output logic                    o_is_halted
);

        import pipe_pkg::*;

        logic [`WORD_W-1:0]     if_instr;
        logic                   if_valid;
        logic                   halt_seen;
        id_ex_t                 id_ex;
        ex_wb_t                 ex_wb;

        rf_if rf_bus ();

        // --------------------
        // input side
        // --------------------
        fetch_unit u_fetch (
                .clk            (clk),
                .reset_n        (reset_n),
                .i_instr        (i_i_data),
                .i_halt_seen    (halt_seen),
                .o_pc           (o_i_address),
                .o_read         (o_i_readM),
                .o_instr        (if_instr),
                .o_valid        (if_valid)
        );

        // --------------------
        // processing
        // --------------------
        decode_stage u_decode (
                .clk            (clk),
                .reset_n        (reset_n),
                .i_instr        (if_instr),
                .i_valid        (if_valid),
                .o_halt_seen    (halt_seen),
                .rf             (rf_bus.decode),
                .o_id_ex        (id_ex)
        );

        reg_file u_reg_file (
                .clk            (clk),
                .reset_n        (reset_n),
                .rf             (rf_bus.regfile)
        );

        execute_stage u_execute (
                .clk            (clk),
                .reset_n        (reset_n),
                .i_id_ex        (id_ex),
                .o_ex_wb        (ex_wb)
        );

        // --------------------
        // output side
        // --------------------
        writeback_stage u_writeback (
                .clk            (clk),
                .reset_n        (reset_n),
                .i_ex_wb        (ex_wb),
                .rf             (rf_bus.writeback),
                .o_output_port  (o_output_port),
                .o_wwd_valid    (o_wwd_valid),
                .o_num_inst     (o_num_inst),
                .o_is_halted    (o_is_halted)
        );

endmodule

// ==== dv/cpu_tb.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu_tb;

        import isa_pkg::*;

        localparam int MEM_N   = 256;
        localparam int TIMEOUT = 500;   // cycles allowed per wait

        logic                   clk;
        logic                   reset_n;
        logic [`WORD_W-1:0]     i_i_data;
        logic [`WORD_W-1:0]     o_i_address;
        logic                   o_i_readM;
        logic [`WORD_W-1:0]     o_output_port;
        logic                   o_wwd_valid;
        logic [`WORD_W-1:0]     o_num_inst;
        logic                   o_is_halted;

        logic [`WORD_W-1:0]     imem [MEM_N];
        logic [`WORD_W-1:0]     prog [$];
        logic [`WORD_W-1:0]     exp_wwd [$];    // expected output port values in order
        int                     exp_count;
        int                     errors;
        int                     timeouts;
        int                     seed;

        cpu_top UUT (
                .clk            (clk),
                .reset_n        (reset_n),
                .o_i_address    (o_i_address),
                .o_i_readM      (o_i_readM),
                .i_i_data       (i_i_data),
                .o_output_port  (o_output_port),
                .o_wwd_valid    (o_wwd_valid),
                .o_num_inst     (o_num_inst),
                .o_is_halted    (o_is_halted)
        );

        // instruction port answers in the same cycle
        assign i_i_data = imem[o_i_address[7:0]];

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        // --------------------
        // encoding helpers
        // --------------------
        function automatic logic [`WORD_W-1:0] enc_r(func_e f, int rs, int rt, int rd);
                return {OPC_RTYPE, 2'(rs), 2'(rt), 2'(rd), f};
        endfunction

        function automatic logic [`WORD_W-1:0] enc_i(opcode_e op, int rs, int rt,
                                                     logic [7:0] imm);
                return {op, 2'(rs), 2'(rt), imm};
        endfunction

        // junk WWD words beyond the program
        function automatic logic [`WORD_W-1:0] fill_word(int addr);
                logic [7:0] a;
                a = 8'(addr);
                return {4'hF, a[7:2] ^ a[5:0], 6'd28};
        endfunction

        function automatic void load_mem();
                for (int i = 0; i < MEM_N; i++) begin
                        imem[i] = fill_word(i);
                end
                for (int i = 0; i < prog.size(); i++) begin
                        imem[i] = prog[i];
                end
        endfunction

        // --------------------
        // reference model
        // --------------------
        // in-order run of imem that fills exp_wwd and counts retired words up to HLT
        function automatic int ref_run();
                logic [`WORD_W-1:0]     r [`REG_N];
                logic [`WORD_W-1:0]     w;
                logic [`WORD_W-1:0]     a;
                logic [`WORD_W-1:0]     b;
                logic [`WORD_W-1:0]     imm_s;
                logic [`WORD_W-1:0]     imm_z;
                int                     n;
                n = 0;
                exp_wwd.delete();
                for (int i = 0; i < `REG_N; i++) begin
                        r[i] = '0;
                end
                for (int pc = 0; pc < MEM_N; pc++) begin
                        w     = imem[pc];
                        a     = r[w[11:10]];
                        b     = r[w[9:8]];
                        imm_s = {{8{w[7]}}, w[7:0]};
                        imm_z = {8'h00, w[7:0]};
                        n++;    // taken back for unknown words
                        case (w[15:12])
                        OPC_ADI: r[w[9:8]] = a + imm_s;
                        OPC_ORI: r[w[9:8]] = a | imm_z;
                        OPC_LHI: r[w[9:8]] = {w[7:0], 8'h00};
                        OPC_RTYPE: begin
                                case (w[5:0])
                                FUNC_ADD: r[w[7:6]] = a + b;
                                FUNC_SUB: r[w[7:6]] = a - b;
                                FUNC_AND: r[w[7:6]] = a & b;
                                FUNC_ORR: r[w[7:6]] = a | b;
                                FUNC_NOT: r[w[7:6]] = ~a;
                                FUNC_TCP: r[w[7:6]] = 16'h0000 - a;
                                FUNC_SHL: r[w[7:6]] = a << 1;
                                FUNC_SHR: r[w[7:6]] = 16'($signed(a) >>> 1);
                                FUNC_WWD: exp_wwd.push_back(a);
                                FUNC_HLT: return n;
                                default:  n--;
                                endcase
                        end
                        default: n--;
                        endcase
                end
                return n;
        endfunction

        // --------------------
        // checking
        // --------------------
        function automatic void check_value(string what, logic [`WORD_W-1:0] got,
                                            logic [`WORD_W-1:0] exp);
                assert (got === exp) else begin
                        errors++;
                        $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
                end
        endfunction

        // outputs are sampled half a cycle after they change
        always @(negedge clk) begin
                if (reset_n && o_wwd_valid) begin
                        assert (exp_wwd.size() > 0) else begin
                                errors++;
                                $display("WWD output %h arrived with no value expected at %0t",
                                         o_output_port, $time);
                        end
                        if (exp_wwd.size() > 0) begin
                                check_value("WWD output", o_output_port, exp_wwd.pop_front());
                        end
                end
        end

        task automatic end_of_test();
                $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
                if (errors == 0 && timeouts == 0) begin
                        $display("test passed");
                end else begin
                        $display("test failed");
                end
                $finish;
        endtask

        task automatic apply_reset();
                @(posedge clk);
                #1 reset_n = 1'b0;
                repeat (3) @(posedge clk);
                #1 reset_n = 1'b1;
        endtask

        task automatic wait_halt(string name);
                int cyc;
                cyc = 0;
                while (!o_is_halted && cyc < TIMEOUT) begin
                        @(negedge clk);
                        cyc++;
                end
                if (!o_is_halted) begin
                        $display("%s did not halt within %0d cycles", name, TIMEOUT);
                        timeouts++;
                end
        endtask

        task automatic run_program(string name);
                @(posedge clk);
                #1;
                load_mem();
                exp_count = ref_run();
                apply_reset();
                @(negedge clk);
                // state straight out of reset
                check_value("i_address", o_i_address, `RESET_PC);
                check_value("i_readM", 16'(o_i_readM), '0);
                check_value("wwd_valid", 16'(o_wwd_valid), '0);
                check_value("is_halted", 16'(o_is_halted), '0);
                check_value("output_port", o_output_port, '0);
                check_value("num_inst", o_num_inst, '0);
                wait_halt(name);
                if (o_is_halted) begin
                        check_value("retired count", o_num_inst, 16'(exp_count));
                        for (int i = 0; i < 20; i++) begin
                                @(negedge clk);
                                assert (o_is_halted && !o_i_readM) else begin
                                        errors++;
                                        $display("%s left the halted state or kept fetching at %0t",
                                                 name, $time);
                                end
                        end
                        assert (exp_wwd.size() == 0) else begin
                                errors++;
                                $display("%s: %0d expected WWD values never appeared",
                                         name, exp_wwd.size());
                        end
                        check_value("retired count after halt", o_num_inst, 16'(exp_count));
                end
        endtask

        // --------------------
        // programs
        // --------------------
        task automatic build_forwarding();
                prog.delete();
                prog.push_back(enc_i(OPC_ADI, 0, 1, 8'h05));    // r1 = 5
                prog.push_back(enc_r(FUNC_ADD, 1, 1, 2));       // distance 1
                prog.push_back(enc_r(FUNC_WWD, 2, 0, 0));
                prog.push_back(enc_r(FUNC_SHL, 2, 0, 3));       // distance 2 from ADD
                prog.push_back(enc_i(OPC_ADI, 3, 1, 8'hFD));    // r1 = r3 - 3
                prog.push_back(enc_r(FUNC_WWD, 3, 0, 0));
                prog.push_back(enc_r(FUNC_WWD, 1, 0, 0));
                prog.push_back(enc_r(FUNC_ADD, 1, 3, 0));
                prog.push_back(enc_r(FUNC_SHL, 0, 0, 0));
                prog.push_back(enc_r(FUNC_WWD, 0, 0, 0));
                prog.push_back(enc_r(FUNC_HLT, 0, 0, 0));
        endtask

        task automatic build_all_ops();
                prog.delete();
                prog.push_back(enc_i(OPC_LHI, 0, 1, 8'h12));
                prog.push_back(enc_i(OPC_ORI, 1, 1, 8'h34));    // r1 = 1234
                prog.push_back(enc_r(FUNC_WWD, 1, 0, 0));
                prog.push_back(enc_i(OPC_ADI, 0, 2, 8'h5A));
                prog.push_back(enc_r(FUNC_SUB, 1, 2, 3));
                prog.push_back(enc_r(FUNC_WWD, 3, 0, 0));
                prog.push_back(enc_r(FUNC_AND, 1, 2, 3));
                prog.push_back(enc_r(FUNC_WWD, 3, 0, 0));
                prog.push_back(enc_r(FUNC_ORR, 1, 2, 3));
                prog.push_back(enc_r(FUNC_WWD, 3, 0, 0));
                prog.push_back(enc_r(FUNC_NOT, 1, 0, 3));
                prog.push_back(enc_r(FUNC_WWD, 3, 0, 0));
                prog.push_back(enc_r(FUNC_TCP, 1, 0, 3));
                prog.push_back(enc_r(FUNC_WWD, 3, 0, 0));
                prog.push_back(enc_i(OPC_ADI, 0, 2, 8'h80));    // negative operand for SHR
                prog.push_back(enc_r(FUNC_SHR, 2, 0, 3));
                prog.push_back(enc_r(FUNC_WWD, 3, 0, 0));
                prog.push_back(enc_r(FUNC_HLT, 0, 0, 0));
        endtask

        task automatic build_random(int len);
                int             k;
                int             rs;
                int             rt;
                int             rd;
                logic [7:0]     imm;
                prog.delete();
                for (int i = 0; i < len; i++) begin
                        k   = {$random(seed)} % 14;
                        rs  = {$random(seed)} % 4;
                        rt  = {$random(seed)} % 4;
                        rd  = {$random(seed)} % 4;
                        imm = 8'($random(seed));
                        case (k)
                        0:  prog.push_back(enc_i(OPC_ADI, rs, rt, imm));
                        1:  prog.push_back(enc_i(OPC_ORI, rs, rt, imm));
                        2:  prog.push_back(enc_i(OPC_LHI, rs, rt, imm));
                        11, 12, 13: prog.push_back(enc_r(FUNC_WWD, rs, 0, 0));
                        default: prog.push_back(enc_r(func_e'(6'(k - 3)), rs, rt, rd));
                        endcase
                end
                prog.push_back(enc_r(FUNC_HLT, 0, 0, 0));
        endtask

        initial begin
                reset_n  = 1'b0;
                errors   = 0;
                timeouts = 0;
                seed     = 32'h69e3ef35;
                prog.delete();
                load_mem();
                build_forwarding();
                run_program("forwarding program");
                build_all_ops();
                run_program("operation program");
                build_random(60);
                run_program("random program");
                end_of_test();
        end

endmodule

// ==== compile.f ====
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/rf_if.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/cpu_top.sv
dv/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run of the pipelined core testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := compile.f $(wildcard hw/*.sv hw/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) --binary --assert --top-module $(TOP) --Mdir $(BUILD_DIR) $(VFLAGS) -f compile.f

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "test passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
